/* Makefile */
# Verilator build and run for the execute slice testbench

TOP := tb_exec

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

/* alu.sv */
`default_nettype none

module alu (
    input  wire exec_pkg::alu_op_t          op,
    input  wire logic [exec_pkg::xlen-1:0]  a,
    input  wire logic [exec_pkg::xlen-1:0]  b,
    output logic      [exec_pkg::xlen-1:0]  result,
    output logic                            zero
);

    // Shift amount, RV32I style, upper bits of b ignored
    logic [exec_pkg::shamt_w-1:0] shamt;

    // Signed views of the operands for slt and sra
    logic signed [exec_pkg::xlen-1:0] a_s;
    logic signed [exec_pkg::xlen-1:0] b_s;

    // Single-bit compare outcomes
    logic lt_signed;
    logic lt_unsigned;

    assign shamt = b[exec_pkg::shamt_w-1:0];
    assign a_s   = $signed(a);
    assign b_s   = $signed(b);

    assign lt_signed   = (a_s < b_s);
    assign lt_unsigned = (a < b);

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            exec_pkg::op_add: begin
                // No carry or overflow out
                result = a + b;
            end
            exec_pkg::op_sub: begin
                result = a - b;
            end
            exec_pkg::op_sll: begin
                result = a << shamt;
            end
            exec_pkg::op_slt: begin
                // One or zero, zero-extended
                result = {{(exec_pkg::xlen-1){1'b0}}, lt_signed};
            end
            exec_pkg::op_sltu: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            exec_pkg::op_xor: begin
                result = a ^ b;
            end
            exec_pkg::op_srl: begin
                // Logical, fills with zeros
                result = a >> shamt;
            end
            exec_pkg::op_sra: begin
                // Arithmetic, copies the sign bit
                result = a_s >>> shamt;
            end
            exec_pkg::op_or: begin
                result = a | b;
            end
            exec_pkg::op_and: begin
                result = a & b;
            end
            exec_pkg::op_pass: begin
                // Operand b straight through
                result = b;
            end
            default: begin
                // Undefined code
                result = '0;
            end
        endcase
    end

    // Zero flag on the final result
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* cmd_fifo.sv */
`default_nettype none

module cmd_fifo (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // Incoming command
    input  wire                                  cmd_valid,
    input  wire exec_pkg::alu_op_t               cmd_op,
    input  wire logic [exec_pkg::reg_addr_w-1:0] cmd_rd,
    input  wire logic [exec_pkg::reg_addr_w-1:0] cmd_rs1,
    input  wire logic [exec_pkg::reg_addr_w-1:0] cmd_rs2,
    input  wire logic [exec_pkg::xlen-1:0]       cmd_imm,
    input  wire                                  cmd_use_imm,
    // Head side
    input  wire                                  pop,
    output logic                                 empty,
    output exec_pkg::alu_op_t                    head_op,
    output logic      [exec_pkg::reg_addr_w-1:0] head_rd,
    output logic      [exec_pkg::reg_addr_w-1:0] head_rs1,
    output logic      [exec_pkg::reg_addr_w-1:0] head_rs2,
    output logic      [exec_pkg::xlen-1:0]       head_imm,
    output logic                                 head_use_imm,
    // Credit back to sender
    output logic                                 cmd_credit
);

    // Storage, one array per command field
    exec_pkg::alu_op_t               op_mem      [exec_pkg::cmd_depth];
    logic [exec_pkg::reg_addr_w-1:0] rd_mem      [exec_pkg::cmd_depth];
    logic [exec_pkg::reg_addr_w-1:0] rs1_mem     [exec_pkg::cmd_depth];
    logic [exec_pkg::reg_addr_w-1:0] rs2_mem     [exec_pkg::cmd_depth];
    logic [exec_pkg::xlen-1:0]       imm_mem     [exec_pkg::cmd_depth];
    logic                            use_imm_mem [exec_pkg::cmd_depth];

    // Pointers carry one extra wrap bit
    logic [exec_pkg::cmd_ptr_w:0] wr_ptr;
    logic [exec_pkg::cmd_ptr_w:0] rd_ptr;

    // Slot indices
    logic [exec_pkg::cmd_ptr_w-1:0] wr_idx;
    logic [exec_pkg::cmd_ptr_w-1:0] rd_idx;

    assign wr_idx = wr_ptr[exec_pkg::cmd_ptr_w-1:0];
    assign rd_idx = rd_ptr[exec_pkg::cmd_ptr_w-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and credit return
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            cmd_credit <= 1'b0;
        end else begin
            // Sender holds a credit, so never full here
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // One credit per freed slot
            cmd_credit <= pop;
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_mem[wr_idx]      <= cmd_op;
            rd_mem[wr_idx]      <= cmd_rd;
            rs1_mem[wr_idx]     <= cmd_rs1;
            rs2_mem[wr_idx]     <= cmd_rs2;
            imm_mem[wr_idx]     <= cmd_imm;
            use_imm_mem[wr_idx] <= cmd_use_imm;
        end
    end

    // Head visible the cycle after the write
    assign empty        = (wr_ptr == rd_ptr);
    assign head_op      = op_mem[rd_idx];
    assign head_rd      = rd_mem[rd_idx];
    assign head_rs1     = rs1_mem[rd_idx];
    assign head_rs2     = rs2_mem[rd_idx];
    assign head_imm     = imm_mem[rd_idx];
    assign head_use_imm = use_imm_mem[rd_idx];

endmodule

`default_nettype wire

/* credit_counter.sv */
`default_nettype none

module credit_counter (
    input  wire  clk,
    input  wire  rst_n,
    // Grant from the result receiver
    input  wire  credit_in,
    // One result sent
    input  wire  consume,
    output logic has_credit
);

    // Credits held, zero after reset
    logic [exec_pkg::res_cnt_w-1:0] count;

    // Headroom checks for the saturating count
    logic at_max;
    logic at_min;

    assign at_max = (count == exec_pkg::res_credits[exec_pkg::res_cnt_w-1:0]);
    assign at_min = (count == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Count update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({credit_in, consume})
                2'b10: begin
                    // Grant only, stop at the maximum
                    if (!at_max) begin
                        count <= count + 1'b1;
                    end
                end
                2'b01: begin
                    // Use only
                    if (!at_min) begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    // Both or neither, net zero
                    count <= count;
                end
            endcase
        end
    end

    assign has_credit = !at_min;

endmodule

`default_nettype wire

/* exec_ctrl.sv */
`default_nettype none

module exec_ctrl (
    input  wire                            clk,
    input  wire                            rst_n,
    // Status from buffer and credit counter
    input  wire                            empty,
    input  wire                            has_credit,
    // Register file read
    output logic                           rd_en,
    // ALU outputs and their registered copies
    input  wire logic [exec_pkg::xlen-1:0] alu_result,
    input  wire                            alu_zero,
    output logic      [exec_pkg::xlen-1:0] result_q,
    output logic                           zero_q,
    // Writeback strobes
    output logic                           wr_en,
    output logic                           pop,
    output logic                           consume,
    output logic                           res_valid
);

    exec_pkg::exec_state_t state;
    exec_pkg::exec_state_t state_next;

    // Writeback can complete this cycle
    logic wb_fire;

    assign wb_fire = (state == exec_pkg::st_writeback) && has_credit;

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= exec_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            exec_pkg::st_idle: begin
                // Head command waiting
                if (!empty) begin
                    state_next = exec_pkg::st_read;
                end
            end
            exec_pkg::st_read: begin
                // Operands land at the end of this cycle
                state_next = exec_pkg::st_execute;
            end
            exec_pkg::st_execute: begin
                // ALU result captured this cycle
                state_next = exec_pkg::st_writeback;
            end
            exec_pkg::st_writeback: begin
                // Hold until a result credit is there
                if (has_credit) begin
                    state_next = exec_pkg::st_idle;
                end
            end
            default: begin
                state_next = exec_pkg::st_idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
            zero_q   <= 1'b0;
        end else if (state == exec_pkg::st_execute) begin
            result_q <= alu_result;
            zero_q   <= alu_zero;
        end
    end

    // Read the head operands in the read state
    assign rd_en = (state == exec_pkg::st_read);

    // All writeback strobes in one cycle
    assign wr_en     = wb_fire;
    assign pop       = wb_fire;
    assign consume   = wb_fire;
    assign res_valid = wb_fire;

endmodule

`default_nettype wire

/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word and index sizes
    ////////////////////////////////////////////////////////////////////////////

    // Data word width
    localparam int xlen       = 32;
    // Register index, 32 architectural registers
    localparam int reg_addr_w = 5;
    // Shift amount, low bits of operand b only
    localparam int shamt_w    = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Flow control counts
    ////////////////////////////////////////////////////////////////////////////

    // Command buffer slots, also the sender's initial credits
    localparam int cmd_depth   = 4;
    localparam int cmd_ptr_w   = $clog2(cmd_depth);
    // Result credits we can hold at most
    localparam int res_credits = 4;
    localparam int res_cnt_w   = $clog2(res_credits + 1);

    // ALU opcodes, codes 11..15 are undefined and give zero
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_sll  = 4'd2,
        op_slt  = 4'd3,
        op_sltu = 4'd4,
        op_xor  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_or   = 4'd8,
        op_and  = 4'd9,
        op_pass = 4'd10
    } alu_op_t;

    // Execute controller states
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_read      = 2'd1,
        st_execute   = 2'd2,
        st_writeback = 2'd3
    } exec_state_t;

endpackage

`default_nettype wire

/* exec_top.sv */
`default_nettype none

module exec_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // Command channel
    input  wire                                  cmd_valid,
    input  wire exec_pkg::alu_op_t               cmd_op,
    input  wire logic [exec_pkg::reg_addr_w-1:0] cmd_rd,
    input  wire logic [exec_pkg::reg_addr_w-1:0] cmd_rs1,
    input  wire logic [exec_pkg::reg_addr_w-1:0] cmd_rs2,
    input  wire logic [exec_pkg::xlen-1:0]       cmd_imm,
    input  wire                                  cmd_use_imm,
    output logic                                 cmd_credit,
    // Result channel
    input  wire                                  res_credit,
    output logic                                 res_valid,
    output logic      [exec_pkg::reg_addr_w-1:0] res_rd,
    output logic      [exec_pkg::xlen-1:0]       res_value,
    output logic                                 res_zero
);

    // Buffer head
    logic                            empty;
    exec_pkg::alu_op_t               head_op;
    logic [exec_pkg::reg_addr_w-1:0] head_rd;
    logic [exec_pkg::reg_addr_w-1:0] head_rs1;
    logic [exec_pkg::reg_addr_w-1:0] head_rs2;
    logic [exec_pkg::xlen-1:0]       head_imm;
    logic                            head_use_imm;

    // Control strobes
    logic pop;
    logic has_credit;
    logic consume;
    logic rd_en;
    logic wr_en;

    // Datapath
    logic [exec_pkg::xlen-1:0] rs1_data;
    logic [exec_pkg::xlen-1:0] rs2_data;
    logic [exec_pkg::xlen-1:0] operand_b;
    logic [exec_pkg::xlen-1:0] alu_result;
    logic                      alu_zero;

    ////////////////////////////////////////////////////////////////////////////
    // Command buffer and result credits
    ////////////////////////////////////////////////////////////////////////////

    cmd_fifo u_cmd_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_rd       (cmd_rd),
        .cmd_rs1      (cmd_rs1),
        .cmd_rs2      (cmd_rs2),
        .cmd_imm      (cmd_imm),
        .cmd_use_imm  (cmd_use_imm),
        .pop          (pop),
        .empty        (empty),
        .head_op      (head_op),
        .head_rd      (head_rd),
        .head_rs1     (head_rs1),
        .head_rs2     (head_rs2),
        .head_imm     (head_imm),
        .head_use_imm (head_use_imm),
        .cmd_credit   (cmd_credit)
    );

    credit_counter u_credit_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .credit_in  (res_credit),
        .consume    (consume),
        .has_credit (has_credit)
    );

    exec_ctrl u_exec_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .has_credit (has_credit),
        .rd_en      (rd_en),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .result_q   (res_value),
        .zero_q     (res_zero),
        .wr_en      (wr_en),
        .pop        (pop),
        .consume    (consume),
        .res_valid  (res_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Register file and ALU
    ////////////////////////////////////////////////////////////////////////////

    // Destination stays at the head until the pop
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rs1      (head_rs1),
        .rs2      (head_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .rd       (head_rd),
        .rd_data  (res_value)
    );

    // Immediate or rs2 as operand b
    assign operand_b = head_use_imm ? head_imm : rs2_data;

    alu u_alu (
        .op     (head_op),
        .a      (rs1_data),
        .b      (operand_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign res_rd = head_rd;

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // Read side
    input  wire                                  rd_en,
    input  wire logic [exec_pkg::reg_addr_w-1:0] rs1,
    input  wire logic [exec_pkg::reg_addr_w-1:0] rs2,
    output logic      [exec_pkg::xlen-1:0]       rs1_data,
    output logic      [exec_pkg::xlen-1:0]       rs2_data,
    // Write side
    input  wire                                  wr_en,
    input  wire logic [exec_pkg::reg_addr_w-1:0] rd,
    input  wire logic [exec_pkg::xlen-1:0]       rd_data
);

    localparam int num_regs = 2 ** exec_pkg::reg_addr_w;

    // Architectural registers, entry zero is never written
    logic [exec_pkg::xlen-1:0] regs [num_regs];

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd != '0)) begin
            // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports, registered
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs1_data <= '0;
            rs2_data <= '0;
        end else if (rd_en) begin
            // Data valid the cycle after rd_en
            rs1_data <= regs[rs1];
            rs2_data <= regs[rs2];
        end
    end

endmodule

`default_nettype wire

/* tb_exec.sv */
`default_nettype none

module tb_exec;

    timeunit 1ns;
    timeprecision 100ps;

    // Longest wait for any handshake, in clock cycles
    localparam int wait_limit = 200;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      cmd_valid;
    exec_pkg::alu_op_t         cmd_op;
    logic [4:0]                cmd_rd;
    logic [4:0]                cmd_rs1;
    logic [4:0]                cmd_rs2;
    logic [31:0]               cmd_imm;
    logic                      cmd_use_imm;
    logic                      cmd_credit;
    logic                      res_credit;
    logic                      res_valid;
    logic [4:0]                res_rd;
    logic [31:0]               res_value;
    logic                      res_zero;

    // Reference model, shadow registers and expected results in order
    logic [31:0] shadow [32];
    logic [4:0]  exp_rd [1024];
    logic [31:0] exp_val [1024];
    int          exp_wr;
    int          res_count;
    int          cmd_sent;
    int          credit_pulses;
    // 0 manual, 1 every cycle, 2 random
    int          grant_mode;
    int          seed = 32'h40ee_1b13;

    always #4 clk = ~clk;

    exec_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_rd      (cmd_rd),
        .cmd_rs1     (cmd_rs1),
        .cmd_rs2     (cmd_rs2),
        .cmd_imm     (cmd_imm),
        .cmd_use_imm (cmd_use_imm),
        .cmd_credit  (cmd_credit),
        .res_credit  (res_credit),
        .res_valid   (res_valid),
        .res_rd      (res_rd),
        .res_value   (res_value),
        .res_zero    (res_zero)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] time %0d ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic report_timeout(input string msg);
        $display("Timed out after %0d cycles: %s", wait_limit, msg);
        stop_on_failure();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference ALU, RV32I rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_alu(input exec_pkg::alu_op_t op,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            exec_pkg::op_add:  return a + b;
            exec_pkg::op_sub:  return a - b;
            exec_pkg::op_sll:  return a << sh;
            exec_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::op_sltu: return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::op_xor:  return a ^ b;
            exec_pkg::op_srl:  return a >> sh;
            exec_pkg::op_sra:  return $unsigned($signed(a) >>> sh);
            exec_pkg::op_or:   return a | b;
            exec_pkg::op_and:  return a & b;
            exec_pkg::op_pass: return b;
            default:           return 32'd0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////////////

    // One clock, then result credit for the new cycle
    task automatic step_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        case (grant_mode)
            1: res_credit = 1'b1;
            2: begin
                r = $random(seed);
                res_credit = r[0];
            end
            default: res_credit = 1'b0;
        endcase
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        res_credit  = 1'b0;
        grant_mode  = 0;
        exp_wr      = 0;
        cmd_sent    = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Waits for a command credit, models the command, drives it for one cycle
    task automatic send_cmd(input exec_pkg::alu_op_t op, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [31:0] imm, input logic use_imm);
        logic [31:0] b;
        int          waited;
        waited = 0;
        while (cmd_sent - credit_pulses >= exec_pkg::cmd_depth) begin
            step_cycle();
            waited++;
            if (waited > wait_limit) report_timeout("no command credit came back");
        end
        b = use_imm ? imm : shadow[rs2];
        exp_rd[exp_wr]  = rd;
        exp_val[exp_wr] = model_alu(op, shadow[rs1], b);
        if (rd != 5'd0) shadow[rd] = exp_val[exp_wr];
        exp_wr++;
        cmd_op      = op;
        cmd_rd      = rd;
        cmd_rs1     = rs1;
        cmd_rs2     = rs2;
        cmd_imm     = imm;
        cmd_use_imm = use_imm;
        cmd_valid   = 1'b1;
        cmd_sent++;
        step_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (res_count < target) begin
            step_cycle();
            waited++;
            if (waited > wait_limit) report_timeout("expected results did not arrive");
        end
    endtask

    // Op into rd, then rd copied to x30 by an add with x0
    task automatic exec_and_read_back(input exec_pkg::alu_op_t op, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2,
                                      input logic [31:0] imm, input logic use_imm);
        send_cmd(op, rd, rs1, rs2, imm, use_imm);
        send_cmd(exec_pkg::op_add, 5'd30, rd, 5'd0, 32'd0, 1'b0);
    endtask

    // Hand-worked values pin the model itself
    task automatic expect_model_reg(input logic [4:0] rd, input logic [31:0] value);
        assert (shadow[rd] == value)
            else report_error($sformatf("model x%0d is %h, rule gives %h", rd, shadow[rd],
                                        value));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Result and credit monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            res_count     = 0;
            credit_pulses = 0;
        end else begin
            if (cmd_credit) credit_pulses++;
            assert (credit_pulses <= cmd_sent)
                else report_error("more command credits returned than commands sent");
            if (res_valid) begin
                assert (res_count < exp_wr)
                    else report_error("result with no command outstanding");
                assert (res_rd == exp_rd[res_count])
                    else report_error($sformatf("res_rd %0d, expected %0d", res_rd,
                                                exp_rd[res_count]));
                assert (res_value == exp_val[res_count])
                    else report_error($sformatf("res_value %h, expected %h (x%0d)",
                                                res_value, exp_val[res_count], res_rd));
                assert (res_zero == (exp_val[res_count] == 32'd0))
                    else report_error($sformatf("res_zero %b for value %h", res_zero,
                                                exp_val[res_count]));
                res_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_and_pass();
        assert (!res_valid && !cmd_credit)
            else report_error("res_valid or cmd_credit high after reset");
        grant_mode = 1;
        // Never-written registers read zero
        send_cmd(exec_pkg::op_add, 5'd5, 5'd7, 5'd9, 32'd0, 1'b0);
        for (int r = 1; r < 32; r++) begin
            send_cmd(exec_pkg::op_pass, r[4:0], 5'd0, 5'd0,
                     {r[7:0], 8'h5a, ~r[7:0], 8'hc3}, 1'b1);
        end
        wait_results(exp_wr);
    endtask

    task automatic test_opcodes();
        // Operands: negative, small positive, sign bit set, shift of 33
        send_cmd(exec_pkg::op_pass, 5'd1, 5'd0, 5'd0, 32'hffff_fff0, 1'b1);
        send_cmd(exec_pkg::op_pass, 5'd2, 5'd0, 5'd0, 32'h0000_0005, 1'b1);
        send_cmd(exec_pkg::op_pass, 5'd3, 5'd0, 5'd0, 32'h8000_0001, 1'b1);
        send_cmd(exec_pkg::op_pass, 5'd4, 5'd0, 5'd0, 32'd33, 1'b1);
        exec_and_read_back(exec_pkg::op_add, 5'd10, 5'd1, 5'd2, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_sub, 5'd11, 5'd2, 5'd1, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_sll, 5'd12, 5'd3, 5'd0, 32'd31, 1'b1);
        exec_and_read_back(exec_pkg::op_sll, 5'd13, 5'd2, 5'd0, 32'd33, 1'b1);
        exec_and_read_back(exec_pkg::op_slt, 5'd14, 5'd1, 5'd2, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_slt, 5'd15, 5'd2, 5'd1, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_sltu, 5'd16, 5'd1, 5'd2, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_sltu, 5'd17, 5'd2, 5'd1, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_xor, 5'd18, 5'd1, 5'd0, 32'h0f0f_0f0f, 1'b1);
        exec_and_read_back(exec_pkg::op_srl, 5'd19, 5'd3, 5'd0, 32'd31, 1'b1);
        exec_and_read_back(exec_pkg::op_srl, 5'd20, 5'd3, 5'd4, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_sra, 5'd21, 5'd1, 5'd0, 32'd4, 1'b1);
        exec_and_read_back(exec_pkg::op_sra, 5'd22, 5'd3, 5'd0, 32'd33, 1'b1);
        exec_and_read_back(exec_pkg::op_or, 5'd23, 5'd2, 5'd3, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_and, 5'd24, 5'd1, 5'd3, 32'd0, 1'b0);
        exec_and_read_back(exec_pkg::op_pass, 5'd25, 5'd1, 5'd0, 32'hcafe_0042, 1'b1);
        // Undefined code gives zero
        exec_and_read_back(exec_pkg::alu_op_t'(4'd13), 5'd26, 5'd1, 5'd2, 32'd0, 1'b0);
        expect_model_reg(5'd12, 32'h8000_0000);
        expect_model_reg(5'd13, 32'h0000_000a);
        expect_model_reg(5'd14, 32'd1);
        expect_model_reg(5'd16, 32'd0);
        expect_model_reg(5'd20, 32'h4000_0000);
        expect_model_reg(5'd21, 32'hffff_ffff);
        expect_model_reg(5'd22, 32'hc000_0000);
        expect_model_reg(5'd26, 32'd0);
        wait_results(exp_wr);
    endtask

    task automatic test_x0_dest();
        // Value still reported, x0 untouched
        send_cmd(exec_pkg::op_pass, 5'd0, 5'd0, 5'd0, 32'h1234_5678, 1'b1);
        send_cmd(exec_pkg::op_add, 5'd0, 5'd1, 5'd2, 32'd0, 1'b0);
        send_cmd(exec_pkg::op_add, 5'd27, 5'd0, 5'd0, 32'd0, 1'b0);
        expect_model_reg(5'd27, 32'd0);
        wait_results(exp_wr);
    endtask

    task automatic test_backpressure();
        apply_reset();
        for (int i = 1; i <= 4; i++) begin
            send_cmd(exec_pkg::op_pass, i[4:0], 5'd0, 5'd0, 32'h0bad_0000 | i, 1'b1);
        end
        // Window with no credit at all
        repeat (40) step_cycle();
        assert (res_count == 0) else report_error("result sent without a result credit");
        for (int k = 1; k <= 4; k++) begin
            res_credit = 1'b1;
            step_cycle();
            wait_results(k);
            repeat (10) step_cycle();
            assert (res_count == k)
                else report_error($sformatf("%0d results after %0d credits", res_count, k));
        end
    endtask

    task automatic test_random();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        apply_reset();
        grant_mode = 2;
        for (int i = 0; i < 200; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            send_cmd(exec_pkg::alu_op_t'(r1[3:0]), r1[8:4], r1[13:9], r1[18:14], r2, r3[0]);
        end
        wait_results(200);
        // Last credit trails its pop by a cycle
        repeat (3) step_cycle();
        assert (credit_pulses == 200)
            else report_error($sformatf("%0d command credits for 200 commands",
                                        credit_pulses));
    endtask

    initial begin
        cmd_op      = exec_pkg::op_add;
        cmd_rd      = 5'd0;
        cmd_rs1     = 5'd0;
        cmd_rs2     = 5'd0;
        cmd_imm     = 32'd0;
        cmd_use_imm = 1'b0;
        apply_reset();
        test_reset_and_pass();
        test_opcodes();
        test_x0_dest();
        test_backpressure();
        test_random();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
exec_pkg.sv
alu.sv
reg_file.sv
cmd_fifo.sv
credit_counter.sv
exec_ctrl.sv
exec_top.sv
tb_exec.sv
